/* design/cache_pkg.sv */
//////////////////////////////////////////////////////////////////////
// cache package
// geometry of the direct-mapped cache, SDRAM controller command
// codes, burst engine state codes and the tag word layout
//////////////////////////////////////////////////////////////////////
package cache_pkg;

  // 8 words of 4 bytes per line, 64 lines, 2 KB in total
  localparam int unsigned BYTE_BITS = 2;
  localparam int unsigned COLUMN_BITS = 3;
  localparam int unsigned COLUMN_COUNT = 2 ** COLUMN_BITS;
  localparam int unsigned LINE_BITS = 6;
  localparam int unsigned LINE_COUNT = 2 ** LINE_BITS;

  // requester byte address and controller word address
  localparam int unsigned ADDR_BITS = 23;
  localparam int unsigned RAM_ADDR_BITS = 21;
  localparam int unsigned TAG_BITS = ADDR_BITS - LINE_BITS - COLUMN_BITS - BYTE_BITS;

  // edges after the read strobe before the first data word is sampled
  localparam int unsigned READ_WAITS = 4;

  localparam logic [2:0] CMD_REFRESH = 3'b001;
  localparam logic [2:0] CMD_ACTIVATE = 3'b011;
  localparam logic [2:0] CMD_WRITE = 3'b100;
  localparam logic [2:0] CMD_READ = 3'b101;

  // burst engine states
  localparam int unsigned STATE_BITS = 4;
  localparam logic [STATE_BITS-1:0] ST_INIT = 4'd0;
  localparam logic [STATE_BITS-1:0] ST_INIT_ACK = 4'd1;
  localparam logic [STATE_BITS-1:0] ST_CLEAR_WAIT = 4'd2;
  localparam logic [STATE_BITS-1:0] ST_IDLE = 4'd3;
  localparam logic [STATE_BITS-1:0] ST_MISS_CHECK = 4'd4;
  localparam logic [STATE_BITS-1:0] ST_EVICT_ACT = 4'd5;
  localparam logic [STATE_BITS-1:0] ST_EVICT_DATA = 4'd6;
  localparam logic [STATE_BITS-1:0] ST_EVICT_ACK = 4'd7;
  localparam logic [STATE_BITS-1:0] ST_FILL_ACT = 4'd8;
  localparam logic [STATE_BITS-1:0] ST_FILL_WAIT = 4'd9;
  localparam logic [STATE_BITS-1:0] ST_FILL_DATA = 4'd10;
  localparam logic [STATE_BITS-1:0] ST_TAG_COMMIT = 4'd11;
  localparam logic [STATE_BITS-1:0] ST_FILL_DONE = 4'd12;

  // one tag RAM word, either raw or split into flags and tag
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [32-TAG_BITS-3:0] spare;
      logic dirty;
      logic valid;
      logic [TAG_BITS-1:0] tag;
    } f;
  } tag_entry_u;

endpackage

/* design/bram.sv */
//////////////////////////////////////////////////////////////////////
// bram
// single-port block RAM of 32-bit words with byte write enables
// and a registered read
//////////////////////////////////////////////////////////////////////
module bram #(
  parameter int unsigned DEPTH_BITS = cache_pkg::LINE_BITS
) (
  input  logic                  clk,
  input  logic [3:0]            write_enable,
  input  logic [DEPTH_BITS-1:0] address,
  input  logic [31:0]           data_in,
  output logic [31:0]           data_out
);

  logic [31:0] mem [2**DEPTH_BITS];

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (write_enable[i]) begin
        mem[address][8*i +: 8] <= data_in[8*i +: 8];
      end
    end
    // read returns the word as it was before this edge's write
    data_out <= mem[address];
  end

endmodule

/* design/cache_lookup.sv */
//////////////////////////////////////////////////////////////////////
// cache lookup
// splits the requester address, keeps the tag array, detects hit
// and dirty lines and invalidates every line after reset
//////////////////////////////////////////////////////////////////////
module cache_lookup (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 enable,
  input  logic [cache_pkg::ADDR_BITS-1:0]      address,
  input  logic [3:0]                           write_enable,
  input  logic                                 tag_write,
  output logic                                 hit,
  output logic                                 line_dirty,
  output logic [cache_pkg::LINE_BITS-1:0]      line_ix,
  output logic [cache_pkg::COLUMN_BITS-1:0]    column_ix,
  output logic [cache_pkg::RAM_ADDR_BITS-1:0]  cached_line_addr,
  output logic [cache_pkg::RAM_ADDR_BITS-1:0]  fill_line_addr,
  output logic                                 clear_done,
  output logic                                 hit_write
);

  logic [cache_pkg::TAG_BITS-1:0]  addr_tag;
  logic [cache_pkg::LINE_BITS-1:0] tag_addr;
  logic [cache_pkg::LINE_BITS-1:0] clear_ix;
  logic [cache_pkg::LINE_BITS-1:0] line_q;
  logic [3:0]                      tag_we;
  logic                            read_ok;
  cache_pkg::tag_entry_u           stored;
  cache_pkg::tag_entry_u           next_entry;

  // |tag|line|col|00|
  assign column_ix = address[cache_pkg::BYTE_BITS +: cache_pkg::COLUMN_BITS];
  assign line_ix = address[cache_pkg::BYTE_BITS + cache_pkg::COLUMN_BITS +: cache_pkg::LINE_BITS];
  assign addr_tag = address[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];

  // the stored entry only counts once it was read for the current line
  assign hit = read_ok && line_q == line_ix && stored.f.valid && stored.f.tag == addr_tag;
  assign line_dirty = stored.f.valid && stored.f.dirty;
  assign hit_write = enable && hit && write_enable != 4'b0000;

  assign cached_line_addr = {stored.f.tag, line_ix, {cache_pkg::COLUMN_BITS{1'b0}}};
  assign fill_line_addr = {addr_tag, line_ix, {cache_pkg::COLUMN_BITS{1'b0}}};

  always_comb begin
    next_entry.raw = '0;
    tag_we = 4'b0000;
    tag_addr = line_ix;
    if (!clear_done) begin
      // start-up sweep writes all-zero entries
      tag_we = 4'b1111;
      tag_addr = clear_ix;
    end else if (tag_write) begin
      tag_we = 4'b1111;
      next_entry.f.valid = 1'b1;
      next_entry.f.tag = addr_tag;
    end else if (hit_write) begin
      tag_we = 4'b1111;
      next_entry.f.dirty = 1'b1;
      next_entry.f.valid = 1'b1;
      next_entry.f.tag = addr_tag;
    end
  end

  bram #(
    .DEPTH_BITS(cache_pkg::LINE_BITS)
  ) tag_ram (
    .clk,
    .write_enable(tag_we),
    .address(tag_addr),
    .data_in(next_entry.raw),
    .data_out(stored.raw)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clear_ix <= '0;
      clear_done <= 1'b0;
      read_ok <= 1'b0;
    end else begin
      read_ok <= clear_done;
      if (!clear_done) begin
        clear_ix <= clear_ix + 1'b1;
        if (clear_ix == cache_pkg::LINE_COUNT - 1) begin
          clear_done <= 1'b1;
        end
      end
    end
  end

  // line index that the tag RAM output belongs to
  always_ff @(posedge clk) begin
    line_q <= tag_addr;
  end

endmodule

/* design/line_store.sv */
//////////////////////////////////////////////////////////////////////
// line store
// eight column RAMs holding the cached data, written by fills or by
// masked requester writes, read by the requester and by eviction
//////////////////////////////////////////////////////////////////////
module line_store (
  input  logic                                clk,
  input  logic [cache_pkg::LINE_BITS-1:0]     line_ix,
  input  logic [cache_pkg::COLUMN_BITS-1:0]   column_ix,
  input  logic                                hit_write,
  input  logic [3:0]                          write_enable,
  input  logic [31:0]                         data_in,
  input  logic [cache_pkg::COLUMN_COUNT-1:0]  fill_we,
  input  logic [31:0]                         fill_data,
  input  logic [cache_pkg::COLUMN_BITS-1:0]   evict_col,
  output logic [31:0]                         evict_data,
  output logic [31:0]                         data_out
);

  logic [3:0]  col_we    [cache_pkg::COLUMN_COUNT];
  logic [31:0] col_wdata [cache_pkg::COLUMN_COUNT];
  logic [31:0] col_rdata [cache_pkg::COLUMN_COUNT];

  // fills write whole words, requester writes only the masked bytes
  always_comb begin
    for (int i = 0; i < cache_pkg::COLUMN_COUNT; i++) begin
      if (fill_we[i]) begin
        col_we[i] = 4'b1111;
        col_wdata[i] = fill_data;
      end else if (hit_write && column_ix == i) begin
        col_we[i] = write_enable;
        col_wdata[i] = data_in;
      end else begin
        col_we[i] = 4'b0000;
        col_wdata[i] = data_in;
      end
    end
  end

  generate
    for (genvar i = 0; i < cache_pkg::COLUMN_COUNT; i++) begin : g_column
      bram #(
        .DEPTH_BITS(cache_pkg::LINE_BITS)
      ) column_ram (
        .clk,
        .write_enable(col_we[i]),
        .address(line_ix),
        .data_in(col_wdata[i]),
        .data_out(col_rdata[i])
      );
    end
  endgenerate

  assign data_out = col_rdata[column_ix];
  // all columns of the held line are readable at once
  assign evict_data = col_rdata[evict_col];

endmodule

/* design/burst_engine.sv */
//////////////////////////////////////////////////////////////////////
// burst engine
// drives the SDRAM controller: start-up refresh, eviction of dirty
// lines in one write burst and line fills in one read burst
//////////////////////////////////////////////////////////////////////
module burst_engine (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 enable,
  input  logic                                 hit,
  input  logic                                 line_dirty,
  input  logic [cache_pkg::RAM_ADDR_BITS-1:0]  cached_line_addr,
  input  logic [cache_pkg::RAM_ADDR_BITS-1:0]  fill_line_addr,
  input  logic                                 clear_done,
  input  logic [31:0]                          evict_data,
  input  logic                                 sdrc_init_done,
  input  logic                                 sdrc_cmd_ack,
  input  logic [31:0]                          sdrc_rdata,
  output logic                                 sdrc_cmd_en,
  output logic [2:0]                           sdrc_cmd,
  output logic [cache_pkg::RAM_ADDR_BITS-1:0]  sdrc_addr,
  output logic [31:0]                          sdrc_data,
  output logic [7:0]                           sdrc_data_len,
  output logic [3:0]                           sdrc_dqm,
  output logic                                 sdrc_precharge_ctrl,
  output logic                                 sdrc_power_down,
  output logic                                 sdrc_selfrefresh,
  output logic [cache_pkg::COLUMN_BITS-1:0]    evict_col,
  output logic [cache_pkg::COLUMN_COUNT-1:0]   fill_we,
  output logic [31:0]                          fill_data,
  output logic                                 tag_write,
  output logic                                 ready
);

  logic [cache_pkg::STATE_BITS-1:0]              state;
  logic [cache_pkg::COLUMN_BITS-1:0]             col_cnt;
  logic [$clog2(cache_pkg::READ_WAITS + 1)-1:0]  wait_cnt;

  // whole-line bursts, no masking, auto precharge, no power saving
  assign sdrc_data_len = 8'(cache_pkg::COLUMN_COUNT - 1);
  assign sdrc_dqm = 4'b0000;
  assign sdrc_precharge_ctrl = 1'b1;
  assign sdrc_power_down = 1'b0;
  assign sdrc_selfrefresh = 1'b0;
  assign evict_col = col_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= cache_pkg::ST_INIT;
      sdrc_cmd_en <= 1'b0;
      fill_we <= '0;
      tag_write <= 1'b0;
      ready <= 1'b0;
    end else begin
      // command strobe lasts one cycle
      sdrc_cmd_en <= 1'b0;
      case (state)
        cache_pkg::ST_INIT: begin
          if (sdrc_init_done) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= cache_pkg::CMD_REFRESH;
            state <= cache_pkg::ST_INIT_ACK;
          end
        end
        cache_pkg::ST_INIT_ACK: begin
          if (sdrc_cmd_ack) begin
            state <= cache_pkg::ST_CLEAR_WAIT;
          end
        end
        cache_pkg::ST_CLEAR_WAIT: begin
          if (clear_done) begin
            ready <= 1'b1;
            state <= cache_pkg::ST_IDLE;
          end
        end
        cache_pkg::ST_IDLE: begin
          if (enable && !hit) begin
            state <= cache_pkg::ST_MISS_CHECK;
          end
        end
        cache_pkg::ST_MISS_CHECK: begin
          // lookup now reflects the held address
          if (!enable || hit) begin
            state <= cache_pkg::ST_IDLE;
          end else if (line_dirty) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= cache_pkg::CMD_ACTIVATE;
            sdrc_addr <= cached_line_addr;
            state <= cache_pkg::ST_EVICT_ACT;
          end else begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= cache_pkg::CMD_ACTIVATE;
            sdrc_addr <= fill_line_addr;
            state <= cache_pkg::ST_FILL_ACT;
          end
        end
        cache_pkg::ST_EVICT_ACT: begin
          if (sdrc_cmd_ack) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= cache_pkg::CMD_WRITE;
            sdrc_addr <= cached_line_addr;
            col_cnt <= '0;
            state <= cache_pkg::ST_EVICT_DATA;
          end
        end
        cache_pkg::ST_EVICT_DATA: begin
          // first word appears the cycle after the write strobe
          sdrc_data <= evict_data;
          col_cnt <= col_cnt + 1'b1;
          if (col_cnt == cache_pkg::COLUMN_COUNT - 1) begin
            state <= cache_pkg::ST_EVICT_ACK;
          end
        end
        cache_pkg::ST_EVICT_ACK: begin
          if (sdrc_cmd_ack) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= cache_pkg::CMD_ACTIVATE;
            sdrc_addr <= fill_line_addr;
            state <= cache_pkg::ST_FILL_ACT;
          end
        end
        cache_pkg::ST_FILL_ACT: begin
          if (sdrc_cmd_ack) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= cache_pkg::CMD_READ;
            sdrc_addr <= fill_line_addr;
            wait_cnt <= '0;
            state <= cache_pkg::ST_FILL_WAIT;
          end
        end
        cache_pkg::ST_FILL_WAIT: begin
          if (wait_cnt == cache_pkg::READ_WAITS) begin
            fill_data <= sdrc_rdata;
            fill_we <= {{(cache_pkg::COLUMN_COUNT-1){1'b0}}, 1'b1};
            col_cnt <= {{(cache_pkg::COLUMN_BITS-1){1'b0}}, 1'b1};
            state <= cache_pkg::ST_FILL_DATA;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        cache_pkg::ST_FILL_DATA: begin
          fill_data <= sdrc_rdata;
          fill_we <= fill_we << 1;
          col_cnt <= col_cnt + 1'b1;
          if (col_cnt == cache_pkg::COLUMN_COUNT - 1) begin
            // tag goes in together with the last word
            tag_write <= 1'b1;
            state <= cache_pkg::ST_TAG_COMMIT;
          end
        end
        cache_pkg::ST_TAG_COMMIT: begin
          fill_we <= '0;
          tag_write <= 1'b0;
          state <= cache_pkg::ST_FILL_DONE;
        end
        cache_pkg::ST_FILL_DONE: begin
          state <= cache_pkg::ST_IDLE;
        end
        default: begin
          state <= cache_pkg::ST_INIT;
        end
      endcase
    end
  end

endmodule

/* design/cache_top.sv */
//////////////////////////////////////////////////////////////////////
// cache top
// direct-mapped write-back cache between a requester and a burst
// SDRAM controller
//////////////////////////////////////////////////////////////////////
module cache_top (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 enable,
  input  logic [cache_pkg::ADDR_BITS-1:0]      address,
  input  logic [31:0]                          data_in,
  input  logic [3:0]                           write_enable,
  output logic [31:0]                          data_out,
  output logic                                 data_out_ready,
  output logic                                 busy,
  output logic                                 sdrc_cmd_en,
  output logic [2:0]                           sdrc_cmd,
  output logic [cache_pkg::RAM_ADDR_BITS-1:0]  sdrc_addr,
  output logic [7:0]                           sdrc_data_len,
  output logic [31:0]                          sdrc_data,
  output logic [3:0]                           sdrc_dqm,
  output logic                                 sdrc_precharge_ctrl,
  output logic                                 sdrc_power_down,
  output logic                                 sdrc_selfrefresh,
  input  logic                                 sdrc_cmd_ack,
  input  logic                                 sdrc_init_done,
  input  logic [31:0]                          sdrc_rdata
);

  logic                                hit;
  logic                                line_dirty;
  logic                                clear_done;
  logic                                hit_write;
  logic                                tag_write;
  logic                                ready;
  logic [cache_pkg::LINE_BITS-1:0]     line_ix;
  logic [cache_pkg::COLUMN_BITS-1:0]   column_ix;
  logic [cache_pkg::COLUMN_BITS-1:0]   evict_col;
  logic [cache_pkg::RAM_ADDR_BITS-1:0] cached_line_addr;
  logic [cache_pkg::RAM_ADDR_BITS-1:0] fill_line_addr;
  logic [cache_pkg::COLUMN_COUNT-1:0]  fill_we;
  logic [31:0]                         fill_data;
  logic [31:0]                         evict_data;

  // busy through start-up, then on every miss of a held request
  assign busy = !ready || (enable && !hit);
  assign data_out_ready = ready && enable && hit && write_enable == 4'b0000;

  cache_lookup u_lookup (
    .clk, .rst_n, .enable, .address, .write_enable, .tag_write,
    .hit, .line_dirty, .line_ix, .column_ix,
    .cached_line_addr, .fill_line_addr, .clear_done, .hit_write
  );

  line_store u_store (
    .clk, .line_ix, .column_ix, .hit_write, .write_enable, .data_in,
    .fill_we, .fill_data, .evict_col, .evict_data, .data_out
  );

  burst_engine u_engine (
    .clk, .rst_n, .enable, .hit, .line_dirty, .cached_line_addr, .fill_line_addr,
    .clear_done, .evict_data, .sdrc_init_done, .sdrc_cmd_ack, .sdrc_rdata,
    .sdrc_cmd_en, .sdrc_cmd, .sdrc_addr, .sdrc_data, .sdrc_data_len, .sdrc_dqm,
    .sdrc_precharge_ctrl, .sdrc_power_down, .sdrc_selfrefresh,
    .evict_col, .fill_we, .fill_data, .tag_write, .ready
  );

endmodule

/* sim/sdrc_model.sv */
//////////////////////////////////////////////////////////////////////
// sdrc model
// behavioral SDRAM controller with a word memory, command
// acknowledge timing and fixed-latency burst data
//////////////////////////////////////////////////////////////////////
module sdrc_model (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 cmd_en,
  input  logic [2:0]                           cmd,
  input  logic [cache_pkg::RAM_ADDR_BITS-1:0]  addr,
  input  logic [31:0]                          wdata,
  output logic                                 cmd_ack,
  output logic                                 init_done,
  output logic [31:0]                          rdata,
  output logic                                 wr_valid,
  output logic [cache_pkg::RAM_ADDR_BITS-1:0]  wr_addr,
  output logic [31:0]                          wr_word,
  output int                                   write_count
);

  localparam int FIRST_PHASE = cache_pkg::READ_WAITS - 1;

  logic [31:0]                         mem [2**cache_pkg::RAM_ADDR_BITS];
  logic [3:0]                          init_cnt;
  logic [1:0]                          ack_cnt;
  logic [3:0]                          wr_phase;
  logic [3:0]                          rd_phase;
  logic [cache_pkg::RAM_ADDR_BITS-1:0] wr_base;
  logic [cache_pkg::RAM_ADDR_BITS-1:0] rd_base;

  // word a starts as a * 0x00010001 xor 0xc0de0000
  initial begin
    for (int a = 0; a < 2**cache_pkg::RAM_ADDR_BITS; a++) begin
      mem[a] = (32'(a) * 32'h0001_0001) ^ 32'hc0de_0000;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      init_cnt <= '0;
      init_done <= 1'b0;
      ack_cnt <= '0;
      cmd_ack <= 1'b0;
      wr_phase <= '0;
      rd_phase <= '0;
      rdata <= '0;
      wr_valid <= 1'b0;
      write_count <= 0;
    end else begin
      cmd_ack <= 1'b0;
      wr_valid <= 1'b0;
      if (!init_done) begin
        init_cnt <= init_cnt + 1'b1;
        if (init_cnt == 4'd9) begin
          init_done <= 1'b1;
        end
      end
      if (ack_cnt != 0) begin
        ack_cnt <= ack_cnt - 1'b1;
        if (ack_cnt == 2'd1) begin
          cmd_ack <= 1'b1;
        end
      end
      // write burst, one word per edge after the strobe
      if (wr_phase != 0) begin
        mem[wr_base + wr_phase - 1] <= wdata;
        wr_valid <= 1'b1;
        wr_addr <= wr_base + wr_phase - 1;
        wr_word <= wdata;
        if (wr_phase == cache_pkg::COLUMN_COUNT) begin
          wr_phase <= '0;
          ack_cnt <= 2'd3;
        end else begin
          wr_phase <= wr_phase + 1'b1;
        end
      end
      // read burst, first word ready for the engine's sampling edge
      if (rd_phase != 0) begin
        rd_phase <= rd_phase + 1'b1;
        if (rd_phase >= FIRST_PHASE) begin
          rdata <= mem[rd_base + rd_phase - FIRST_PHASE];
        end
        if (rd_phase == FIRST_PHASE + cache_pkg::COLUMN_COUNT - 1) begin
          rd_phase <= '0;
        end
      end
      if (cmd_en) begin
        case (cmd)
          cache_pkg::CMD_REFRESH, cache_pkg::CMD_ACTIVATE: begin
            ack_cnt <= 2'd2;
          end
          cache_pkg::CMD_WRITE: begin
            wr_base <= addr;
            wr_phase <= 4'd1;
            write_count <= write_count + 1;
          end
          cache_pkg::CMD_READ: begin
            rd_base <= addr;
            rd_phase <= 4'd1;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

/* sim/tb_cache.sv */
//////////////////////////////////////////////////////////////////////
// cache testbench
// runs the requests of the cases file against the cache and an
// SDRAM controller model, checking data, hits and evictions
//////////////////////////////////////////////////////////////////////
module tb_cache;

  localparam int MAX_CASES = 24;

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [22:0] address;
  logic [31:0] data_in;
  logic [3:0]  write_enable;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic        sdrc_cmd_en;
  logic [2:0]  sdrc_cmd;
  logic [20:0] sdrc_addr;
  logic [7:0]  sdrc_data_len;
  logic [31:0] sdrc_data;
  logic [3:0]  sdrc_dqm;
  logic        sdrc_precharge_ctrl;
  logic        sdrc_power_down;
  logic        sdrc_selfrefresh;
  logic        sdrc_cmd_ack;
  logic        sdrc_init_done;
  logic [31:0] sdrc_rdata;
  logic        evict_valid;
  logic [20:0] evict_addr;
  logic [31:0] evict_word;
  int          write_count;

  int          mismatches = 0;
  int          failures = 0;
  int          cycles = 0;
  int          limit = 200;
  int          cmd_count = 0;
  int          ack_count = 0;
  logic [31:0] case_words [5*MAX_CASES];
  // memory contents as the requester sees them
  logic [31:0] shadow [2**21];

  cache_top DUT (
    .clk, .rst_n, .enable, .address, .data_in, .write_enable,
    .data_out, .data_out_ready, .busy,
    .sdrc_cmd_en, .sdrc_cmd, .sdrc_addr, .sdrc_data_len, .sdrc_data, .sdrc_dqm,
    .sdrc_precharge_ctrl, .sdrc_power_down, .sdrc_selfrefresh,
    .sdrc_cmd_ack, .sdrc_init_done, .sdrc_rdata
  );

  sdrc_model u_sdrc (
    .clk, .rst_n, .cmd_en(sdrc_cmd_en), .cmd(sdrc_cmd), .addr(sdrc_addr),
    .wdata(sdrc_data), .cmd_ack(sdrc_cmd_ack), .init_done(sdrc_init_done),
    .rdata(sdrc_rdata), .wr_valid(evict_valid), .wr_addr(evict_addr),
    .wr_word(evict_word), .write_count
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout: no end of test after %0d cycles", limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // controller commands and evicted words
  always @(negedge clk) begin
    if (rst_n && sdrc_cmd_en) begin
      cmd_count++;
      assert (sdrc_data_len == 8'd7) else begin
        mismatches++;
        $display("mismatch at %0t: sdrc_data_len got %h expected 07", $time, sdrc_data_len);
      end
      assert (sdrc_dqm == 4'b0000) else begin
        mismatches++;
        $display("mismatch at %0t: sdrc_dqm got %h expected 0", $time, sdrc_dqm);
      end
      // no power saving, bursts close their row by auto precharge
      assert ({sdrc_power_down, sdrc_selfrefresh, sdrc_precharge_ctrl} == 3'b001) else begin
        mismatches++;
        $display("mismatch at %0t: sdrc_power_down/selfrefresh/precharge_ctrl got %b%b%b %s",
                 $time, sdrc_power_down, sdrc_selfrefresh, sdrc_precharge_ctrl,
                 "expected 001");
      end
    end
    if (rst_n && sdrc_cmd_ack) begin
      ack_count++;
    end
    if (rst_n && evict_valid) begin
      assert (evict_word == shadow[evict_addr]) else begin
        mismatches++;
        $display("mismatch at %0t: sdrc_data got %h expected %h", $time, evict_word,
                 shadow[evict_addr]);
      end
    end
  end

  task automatic run_case(input logic [31:0] op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] mask,
                          input logic [31:0] expected);
    int   start_cmds;
    logic saw_busy;
    logic done;
    start_cmds = cmd_count;
    saw_busy = 1'b0;
    done = 1'b0;
    @(posedge clk);
    enable <= 1'b1;
    address <= addr[22:0];
    data_in <= data;
    write_enable <= op[0] ? mask[3:0] : 4'b0000;
    while (!done) begin
      @(negedge clk);
      if (busy) begin
        saw_busy = 1'b1;
      end else begin
        done = 1'b1;
      end
    end
    if (op[0]) begin
      assert (!data_out_ready) else begin
        mismatches++;
        $display("mismatch at %0t: data_out_ready got 1 expected 0", $time);
      end
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          shadow[addr[22:2]][8*b +: 8] = data[8*b +: 8];
        end
      end
    end else begin
      assert (data_out_ready) else begin
        failures++;
        $display("read of %h ended without data_out_ready at %0t", addr, $time);
      end
      assert (data_out == expected) else begin
        mismatches++;
        $display("mismatch at %0t: data_out got %h expected %h", $time, data_out, expected);
      end
    end
    @(posedge clk);
    enable <= 1'b0;
    if (op[4]) begin
      assert (!saw_busy && cmd_count == start_cmds) else begin
        failures++;
        $display("request to %h should have hit but went to the controller", addr);
      end
    end else begin
      assert (saw_busy) else begin
        failures++;
        $display("request to %h should have missed but busy never rose", addr);
      end
    end
  endtask

  initial begin
    int n_cases;
    clk = 1'b0;
    rst_n = 1'b0;
    enable = 1'b0;
    address = '0;
    data_in = '0;
    write_enable = 4'b0000;
    for (int a = 0; a < 2**21; a++) begin
      shadow[a] = (32'(a) * 32'h0001_0001) ^ 32'hc0de_0000;
    end
    $readmemh("sim/cache_cases.txt", case_words);
    n_cases = 0;
    while (n_cases < MAX_CASES - 1 && case_words[5*n_cases] !== 32'h2 &&
           !$isunknown(case_words[5*n_cases])) begin
      n_cases++;
    end
    limit = cycles + n_cases * 80 + 200;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (busy) else begin
      failures++;
      $display("busy was low right after reset");
    end
    // start-up ends only after the refresh was acknowledged
    while (busy) begin
      @(negedge clk);
    end
    assert (cmd_count == 1 && ack_count == 1 && sdrc_cmd == cache_pkg::CMD_REFRESH) else begin
      failures++;
      $display("busy dropped at %0t before the start-up refresh was acknowledged", $time);
    end
    for (int i = 0; i < n_cases; i++) begin
      run_case(case_words[5*i], case_words[5*i+1], case_words[5*i+2],
               case_words[5*i+3], case_words[5*i+4]);
    end
    assert (case_words[5*n_cases] === 32'h2) else begin
      failures++;
      $display("cases file has no end line with the eviction count");
    end
    // the end line carries the number of dirty evictions
    assert (write_count == case_words[5*n_cases+2]) else begin
      mismatches++;
      $display("mismatch at %0t: write_count got %0d expected %0d", $time, write_count,
               case_words[5*n_cases+2]);
    end
    $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* sim/cache_cases.txt */
// op addr wdata mask expected, op 0 read 1 write, +10 expects a hit
// op 2 ends the list, its wdata column is the number of dirty evictions
00 000000 00000000 0 c0de0000
10 00000c 00000000 0 c0dd0003
10 000014 00000000 0 c0db0005
10 00001c 00000000 0 c0d90007
11 00000c a1b2c3d4 3 00000000
11 000014 11223344 c 00000000
10 00000c 00000000 0 c0ddc3d4
10 000014 00000000 0 11220005
00 000800 00000000 0 c2de0200
00 00000c 00000000 0 c0ddc3d4
10 000014 00000000 0 11220005
00 000800 00000000 0 c2de0200
01 000020 deadbeef f 00000000
10 000020 00000000 0 deadbeef
00 000820 00000000 0 c2d60208
00 000020 00000000 0 deadbeef
02 000000 00000002 0 00000000

/* verilog.f */
design/cache_pkg.sv
design/bram.sv
design/cache_lookup.sv
design/line_store.sv
design/burst_engine.sv
design/cache_top.sv
sim/sdrc_model.sv
sim/tb_cache.sv

/* Bender.yml */
package:
  name: cache

sources:
  - target: rtl
    files:
      - design/cache_pkg.sv
      - design/bram.sv
      - design/cache_lookup.sv
      - design/line_store.sv
      - design/burst_engine.sv
      - design/cache_top.sv
  - target: simulation
    files:
      - sim/sdrc_model.sv
      - sim/tb_cache.sv
